//--- Bender.yml
package:
  name: i2c_master

sources:
  - files:
      - hdl/i2c_bus_pkg.sv
      - hdl/i2c_ctrl_pkg.sv
      - hdl/i2c_phase_timer.sv
      - hdl/i2c_byte_shifter.sv
      - hdl/i2c_controller.sv
      - hdl/i2c_master_top.sv
  - target: simulation
    files:
      - sim/i2c_slave_model.sv
      - sim/i2c_master_tb.sv

//--- hdl/i2c_bus_pkg.sv
// I2C protocol types shared by the controller datapath and the bus side
package i2c_bus_pkg;

    // 7-bit slave address as sent in the first byte
    typedef logic [6:0] slave_addr_t;

    // One byte on the wire, address plus R/W or a data byte
    typedef logic [7:0] i2c_byte_t;

    // Bits left to move in the current byte, 0 to 8
    typedef logic [3:0] bit_count_t;

    // SDA level in the ninth clock
    localparam logic ack_level = 1'b0;  // Receiver pulls SDA low
    localparam logic nak_level = 1'b1;  // SDA left released, pulled up

endpackage

//--- hdl/i2c_byte_shifter.sv
`timescale 1ns/1ps

// Byte serialiser for the transmit side, deserialiser for reads
module i2c_byte_shifter (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   load,       // Take load_byte, arm eight bits
    input  i2c_bus_pkg::i2c_byte_t load_byte,
    input  logic                   shift,      // One bit done, SCL going low
    input  logic                   capture,    // Store sda_in on this shift
    input  logic                   sda_in,     // Resolved SDA pin
    output logic                   tx_bit,     // Bit to put on SDA, MSB first
    output logic                   last_bit,   // One bit still to go
    output i2c_bus_pkg::i2c_byte_t read_data   // Assembled read byte
);
    import i2c_bus_pkg::*;

    i2c_byte_t  shift_reg;  // Outgoing byte, moves left on each shift
    bit_count_t bit_count;  // Bits left in the byte
    logic [2:0] bit_index;  // Position of the bit being finished

    assign bit_index = 3'(bit_count - 1'b1);

    // Bit counter is the only control state here
    always_ff @(posedge clock) begin
        if (reset) begin
            bit_count <= '0;
        end else if (load) begin
            bit_count <= bit_count_t'(8);
        end else if (shift) begin
            bit_count <= bit_count - 1'b1;
        end
    end

    // Transmit data path
    always_ff @(posedge clock) begin
        if (load) begin
            shift_reg <= load_byte;
        end else if (shift) begin
            shift_reg <= {shift_reg[6:0], 1'b0};  // Next bit into MSB
        end
    end

    // Receive data path, one bit per shift while reading
    always_ff @(posedge clock) begin
        if (shift && capture) begin
            read_data[bit_index] <= sda_in;  // Sampled while SCL still high
        end
    end

    assign tx_bit   = shift_reg[7];
    assign last_bit = (bit_count == bit_count_t'(1));

endmodule

//--- hdl/i2c_controller.sv
`timescale 1ns/1ps

// I2C master transaction FSM, one state step per phase tick
module i2c_controller (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     trigger,     // Start or continue
    input  logic                     restart,     // Next transfer opens with a repeated START
    input  logic                     last_byte,   // Current byte ends the transfer
    input  i2c_bus_pkg::slave_addr_t address,
    input  logic                     read_write,  // 0 write, 1 read
    input  i2c_bus_pkg::i2c_byte_t   write_data,
    input  logic                     tick,        // Phase step from the timer
    input  logic                     tx_bit,
    input  logic                     last_bit,
    input  logic                     sda_in,
    output logic                     busy,
    output logic                     ack_error,   // SDA level seen in the write ACK slot
    output logic                     scl_out,     // 1 releases the pin
    output logic                     sda_out,     // Ditto
    output logic                     load,
    output i2c_bus_pkg::i2c_byte_t   load_byte,
    output logic                     shift,
    output logic                     capture
);
    import i2c_bus_pkg::*;
    import i2c_ctrl_pkg::*;

    ctrl_state_t state;
    logic        running;    // Transfer in progress, gates the timer
    logic        pause_req;  // Drop running on the next clock
    logic        flip;       // Half-bit phase, 0 raises SCL, 1 lowers it
    logic        in_data;    // Eight-bit data states

    assign busy    = running;
    assign in_data = (state == st_write_data) || (state == st_read_data);

    // Shifter strobes follow the tick directly so the shifter moves on the
    // same edge as the FSM; SDA is sampled before SCL actually falls
    assign shift   = tick & flip & in_data;
    assign capture = (state == st_read_data);
    assign load    = tick & (((state == st_start2) & flip)
                             | (state == st_write_wait)
                             | (state == st_read_wait));

    // Address byte carries the R/W flag in the LSB
    assign load_byte = (state == st_start2) ? {address, read_write} : write_data;

    always_ff @(posedge clock) begin
        if (reset) begin
            running <= 1'b0;
        end else if (pause_req) begin
            running <= 1'b0;  // Wait for the host's next trigger
        end else if (trigger) begin
            running <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= st_start1;
            flip      <= 1'b0;
            pause_req <= 1'b0;
            scl_out   <= 1'b1;  // Bus released
            sda_out   <= 1'b1;
            ack_error <= 1'b0;
        end else begin
            pause_req <= 1'b0;

            // SDA only moves while SCL is low, a clock after the falling step
            if (!scl_out) begin
                case (state)
                    st_write_data: sda_out <= tx_bit;
                    st_write_ack,
                    st_write_wait,
                    st_read_data,
                    st_read_wait:  sda_out <= nak_level;  // Let the slave drive
                    st_read_ack:   sda_out <= last_byte ? nak_level : ack_level;
                    default: ;
                endcase
            end

            if (restart) begin
                state <= st_restart1;  // Only pulsed while idle
            end else if (tick) begin
                case (state)
                    st_start1: begin
                        scl_out <= 1'b1;
                        sda_out <= 1'b1;
                        flip    <= 1'b0;
                        state   <= st_start2;
                    end

                    st_start2: begin
                        if (!flip) begin
                            sda_out <= 1'b0;  // START, SCL still high
                            flip    <= 1'b1;
                        end else begin
                            scl_out <= 1'b0;  // Address byte loaded on this step
                            flip    <= 1'b0;
                            state   <= st_write_data;
                        end
                    end

                    st_write_data: begin
                        scl_out <= ~flip;
                        flip    <= ~flip;
                        if (flip && last_bit) begin
                            state <= st_write_ack;
                        end
                    end

                    st_write_ack: begin
                        scl_out <= ~flip;
                        flip    <= ~flip;
                        if (flip) begin
                            ack_error <= sda_in;  // SCL still high here
                            if (last_byte) begin
                                state <= st_stop1;
                            end else begin
                                pause_req <= 1'b1;
                                // Address byte decides the direction of what follows
                                state <= read_write ? st_read_wait : st_write_wait;
                            end
                        end
                    end

                    st_write_wait: state <= st_write_data;  // Next byte loaded now

                    st_read_data: begin
                        scl_out <= ~flip;
                        flip    <= ~flip;
                        if (flip && last_bit) begin
                            state <= st_read_ack;
                        end
                    end

                    st_read_ack: begin
                        scl_out <= ~flip;
                        flip    <= ~flip;
                        if (flip) begin
                            if (last_byte) begin
                                state <= st_stop1;
                            end else begin
                                pause_req <= 1'b1;
                                state     <= st_read_wait;
                            end
                        end
                    end

                    st_read_wait: state <= st_read_data;  // Rearm the bit count

                    st_stop1: begin
                        scl_out <= 1'b0;
                        sda_out <= 1'b0;
                        state   <= st_stop2;
                    end

                    st_stop2: begin
                        scl_out <= 1'b1;
                        state   <= st_stop3;
                    end

                    st_stop3: begin
                        sda_out   <= 1'b1;  // STOP, bus free again
                        pause_req <= 1'b1;
                        state     <= st_start1;
                    end

                    st_restart1: begin
                        // Park SCL low with SDA released before the new START
                        scl_out <= 1'b0;
                        sda_out <= 1'b1;
                        state   <= st_start1;
                    end

                    default: state <= st_start1;
                endcase
            end
        end
    end

endmodule

//--- hdl/i2c_ctrl_pkg.sv
// Controller-internal definitions, not visible on the bus
package i2c_ctrl_pkg;

    // Divider width; one phase tick every 2**phase_div_bits clocks
    localparam int phase_div_bits = 7;

    typedef logic [phase_div_bits-1:0] phase_count_t;

    // Transaction FSM states
    typedef enum logic [3:0] {
        st_start1,      // Bus idle or repeated START setup, both lines high
        st_start2,      // SDA falls with SCL high, then SCL falls
        st_write_data,  // Eight bits out, MSB first
        st_write_ack,   // SDA released, slave ACK sampled
        st_write_wait,  // Paused, next byte to send is loaded here
        st_read_data,   // Eight bits in
        st_read_ack,    // Master ACK, or NAK on the last byte
        st_read_wait,   // Paused between read bytes
        st_stop1,       // SDA low while SCL low
        st_stop2,       // SCL rises
        st_stop3,       // SDA rises with SCL high -> STOP
        st_restart1     // Prepares both lines for a repeated START
    } ctrl_state_t;

endpackage

//--- hdl/i2c_master_top.sv
`timescale 1ns/1ps

// I2C master with open-drain SCL/SDA pins
module i2c_master_top (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     trigger,
    input  logic                     restart,
    input  logic                     last_byte,
    input  i2c_bus_pkg::slave_addr_t address,
    input  logic                     read_write,
    input  i2c_bus_pkg::i2c_byte_t   write_data,
    output i2c_bus_pkg::i2c_byte_t   read_data,
    output logic                     ack_error,
    output logic                     busy,
    inout  wire                      scl,
    inout  wire                      sda
);
    import i2c_bus_pkg::*;

    logic      tick;
    logic      load;
    i2c_byte_t load_byte;
    logic      shift;
    logic      capture;
    logic      tx_bit;
    logic      last_bit;
    logic      scl_out;
    logic      sda_out;
    logic      sda_in;    // Resolved pin level, slave may be pulling low

    i2c_phase_timer u_timer (
        .clock (clock),
        .reset (reset),
        .run   (busy),
        .clear (trigger),  // New phase for each byte
        .tick  (tick)
    );

    i2c_byte_shifter u_shifter (
        .clock     (clock),
        .reset     (reset),
        .load      (load),
        .load_byte (load_byte),
        .shift     (shift),
        .capture   (capture),
        .sda_in    (sda_in),
        .tx_bit    (tx_bit),
        .last_bit  (last_bit),
        .read_data (read_data)
    );

    i2c_controller u_controller (
        .clock      (clock),
        .reset      (reset),
        .trigger    (trigger),
        .restart    (restart),
        .last_byte  (last_byte),
        .address    (address),
        .read_write (read_write),
        .write_data (write_data),
        .tick       (tick),
        .tx_bit     (tx_bit),
        .last_bit   (last_bit),
        .sda_in     (sda_in),
        .busy       (busy),
        .ack_error  (ack_error),
        .scl_out    (scl_out),
        .sda_out    (sda_out),
        .load       (load),
        .load_byte  (load_byte),
        .shift      (shift),
        .capture    (capture)
    );

    // Open drain, external pull-ups give the high level
    assign scl    = scl_out ? 1'bz : 1'b0;
    assign sda    = sda_out ? 1'bz : 1'b0;
    assign sda_in = sda;

endmodule

//--- hdl/i2c_phase_timer.sv
`timescale 1ns/1ps

// Divides the system clock down to the SCL phase rate
module i2c_phase_timer (
    input  logic clock,
    input  logic reset,
    input  logic run,    // Count only while a transfer is active
    input  logic clear,  // Restart the phase, one pulse per trigger
    output logic tick    // One cycle per half SCL period
);
    import i2c_ctrl_pkg::*;

    phase_count_t phase_count;  // Free-running divider
    logic         msb_now;      // Counter MSB this cycle
    logic         msb_prev;     // MSB as seen one counting step earlier

    assign msb_now = phase_count[phase_div_bits-1];

    always_ff @(posedge clock) begin
        if (reset) begin
            phase_count <= '0;
            msb_prev    <= 1'b0;
        end else if (clear) begin
            // Fresh phase for every byte so the first tick is half a period out
            phase_count <= '0;
            msb_prev    <= 1'b0;
        end else if (run) begin
            phase_count <= phase_count + 1'b1;
            msb_prev    <= msb_now;
        end
    end

    // Rising edge of the MSB; counter is frozen when not running
    assign tick = run & msb_now & ~msb_prev;

endmodule

//--- sim.f
hdl/i2c_bus_pkg.sv
hdl/i2c_ctrl_pkg.sv
hdl/i2c_phase_timer.sv
hdl/i2c_byte_shifter.sv
hdl/i2c_controller.sv
hdl/i2c_master_top.sv
sim/i2c_slave_model.sv
sim/i2c_master_tb.sv

//--- sim/i2c_master_tb.sv
`timescale 1ns/1ps

module i2c_master_tb;
    import i2c_bus_pkg::*;

    localparam int          clock_period  = 20;
    localparam slave_addr_t slave_address = 7'h50;
    localparam logic [31:0] mem_seed      = 32'hde0b_48b9;
    localparam int          byte_cycles   = 2600;  // One byte incl. START or STOP
    localparam int          max_bytes     = 40;

    logic        clock;
    logic        reset;
    logic        trigger;
    logic        restart;
    logic        last_byte;
    slave_addr_t address;
    logic        read_write;
    i2c_byte_t   write_data;
    i2c_byte_t   read_data;
    logic        ack_error;
    logic        busy;
    wire         scl;
    wire         sda;
    i2c_byte_t   mem_copy [16];  // Expected slave memory
    integer      seed;

    pullup (scl);
    pullup (sda);

    i2c_master_top uut (
        .clock      (clock),
        .reset      (reset),
        .trigger    (trigger),
        .restart    (restart),
        .last_byte  (last_byte),
        .address    (address),
        .read_write (read_write),
        .write_data (write_data),
        .read_data  (read_data),
        .ack_error  (ack_error),
        .busy       (busy),
        .scl        (scl),
        .sda        (sda)
    );

    i2c_slave_model #(
        .dev_address (slave_address),
        .init_seed   (mem_seed)
    ) slave (
        .scl (scl),
        .sda (sda)
    );

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    initial begin
        #((max_bytes * byte_cycles + 1000) * clock_period);  // Every test byte plus margin
        $display("Timeout: the transfers did not complete in the expected time");
        $display("Something failed");
        $fatal(1);
    end

    task automatic check_value(input logic [31:0] expected, input logic [31:0] actual,
                               input string what);
        if (actual !== expected) begin
            $display("Mismatch at time %0t: %s, expected %0h, got %0h",
                     $time, what, expected, actual);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    // One host step: address byte from idle, or the next data byte
    task automatic run_byte(input i2c_byte_t data, input logic last);
        write_data = data;
        last_byte  = last;
        @(negedge clock);
        trigger = 1'b1;
        @(negedge clock);
        trigger = 1'b0;
        check_value(1, busy, "busy after trigger");
        while (busy) begin
            @(negedge clock);
        end
    endtask

    // Lines held for a while: SCL low in a pause, both high when free
    task automatic check_bus_held(input logic scl_level, input int cycles, input string what);
        repeat (cycles) begin
            @(negedge clock);
            check_value(0, busy, what);
            check_value(scl_level, scl, what);
            if (scl_level) check_value(1, sda, what);
        end
    endtask

    task automatic idle_after_reset();
        check_value(0, busy, "busy after reset");
        check_value(0, ack_error, "ack_error after reset");
        check_bus_held(1'b1, 300, "bus idle after reset");
    endtask

    task automatic write_transfer();
        address    = slave_address;
        read_write = 1'b0;
        run_byte(8'h00, 1'b0);
        check_value(ack_level, ack_error, "write address ACK");
        run_byte(8'h03, 1'b0);
        check_value(ack_level, ack_error, "pointer ACK");
        run_byte(8'ha5, 1'b0);
        check_value(ack_level, ack_error, "first data ACK");
        run_byte(8'h3c, 1'b1);
        check_value(ack_level, ack_error, "last data ACK");
        mem_copy[3] = 8'ha5;
        mem_copy[4] = 8'h3c;
        check_value(mem_copy[3], slave.mem[3], "slave memory at 3");
        check_value(mem_copy[4], slave.mem[4], "slave memory at 4");
        check_bus_held(1'b1, 300, "bus after write STOP");
    endtask

    task automatic wrong_address();
        address    = 7'h23;
        read_write = 1'b0;
        run_byte(8'h00, 1'b0);
        check_value(nak_level, ack_error, "no ACK for unknown address");
        run_byte(8'h5a, 1'b1);  // Finish with a STOP
        check_value(nak_level, ack_error, "no ACK for final byte");
        check_bus_held(1'b1, 300, "bus after unanswered STOP");
    endtask

    task automatic read_with_restart();
        int i;
        address    = slave_address;
        read_write = 1'b0;
        run_byte(8'h00, 1'b0);
        run_byte(8'h08, 1'b0);
        check_value(ack_level, ack_error, "pointer ACK before restart");
        restart = 1'b1;
        @(negedge clock);
        restart    = 1'b0;
        read_write = 1'b1;
        run_byte(8'h00, 1'b0);
        check_value(ack_level, ack_error, "read address ACK");
        for (i = 0; i < 3; i++) begin
            run_byte(8'h00, i == 2);
            check_value(mem_copy[8 + i], read_data, "read byte");
            check_value((i == 2) ? nak_level : ack_level, slave.master_ack,
                        "master ACK seen by slave");
        end
        check_bus_held(1'b1, 300, "bus after read STOP");
    endtask

    task automatic busy_pacing();
        int        i;
        i2c_byte_t data;
        address    = slave_address;
        read_write = 1'b0;
        run_byte(8'h00, 1'b0);
        check_bus_held(1'b0, 300, "pause after address");
        run_byte(8'h0c, 1'b0);
        check_bus_held(1'b0, 300, "pause after pointer");
        for (i = 0; i < 3; i++) begin
            data = i2c_byte_t'($random(seed));
            run_byte(data, i == 2);
            mem_copy[12 + i] = data;
            if (i < 2) check_bus_held(1'b0, 300, "pause between data bytes");
        end
        check_bus_held(1'b1, 300, "bus after final STOP");
        for (i = 12; i < 15; i++) begin
            check_value(mem_copy[i], slave.mem[i], "slave memory after paced write");
        end
    endtask

    initial begin
        int i;
        trigger    = 1'b0;
        restart    = 1'b0;
        last_byte  = 1'b0;
        address    = '0;
        read_write = 1'b0;
        write_data = '0;
        reset      = 1'b1;
        seed       = mem_seed;  // Same sequence the slave loads
        for (i = 0; i < 16; i++) begin
            mem_copy[i] = i2c_byte_t'($random(seed));
        end
        repeat (10) @(negedge clock);
        reset = 1'b0;
        idle_after_reset();
        write_transfer();
        wrong_address();
        read_with_restart();
        busy_pacing();
        $display("Everything OK");
        $finish;
    end

endmodule

//--- sim/i2c_slave_model.sv
`timescale 1ns/1ps

// Behavioural I2C slave, 16-byte register file with an auto-incrementing pointer
module i2c_slave_model #(
    parameter i2c_bus_pkg::slave_addr_t dev_address = 7'h50,
    parameter logic [31:0]              init_seed   = 32'h1
) (
    inout wire scl,
    inout wire sda
);
    import i2c_bus_pkg::*;

    localparam int mem_depth = 16;

    typedef enum logic [1:0] {sl_idle, sl_address, sl_write, sl_read} slave_phase_t;

    i2c_byte_t    mem [mem_depth];      // Register file
    slave_phase_t phase = sl_idle;
    logic         sda_drive = 1'b1;     // 0 pulls SDA low
    logic         master_ack = nak_level;  // Master's level after the last read byte
    logic         ack_slot = 1'b0;      // Ninth clock of a byte
    logic         first_write = 1'b0;   // Next written byte sets the pointer
    logic [3:0]   pointer = '0;
    logic [3:0]   bit_cnt = '0;
    i2c_byte_t    shift_in = '0;
    i2c_byte_t    tx_byte = '0;
    logic         scl_prev = 1'b1;
    logic         sda_prev = 1'b1;
    integer       seed;

    assign sda = sda_drive ? 1'bz : 1'b0;

    initial begin
        int i;
        seed = init_seed;
        for (i = 0; i < mem_depth; i++) begin
            mem[i] = i2c_byte_t'($random(seed));
        end
    end

    always @(scl or sda) begin
        if (scl_prev === 1'b1 && scl === 1'b1 && sda !== sda_prev) begin
            // SDA moved with SCL high: falling is START, rising is STOP
            phase     = (sda === 1'b0) ? sl_address : sl_idle;
            bit_cnt   = '0;
            ack_slot  = 1'b0;
            sda_drive = 1'b1;
        end else if (scl_prev !== 1'b1 && scl === 1'b1 && phase != sl_idle) begin
            if (ack_slot) begin
                if (phase == sl_read && sda_drive) master_ack = sda;  // Not our own ACK
            end else begin
                shift_in = {shift_in[6:0], sda};  // Sample on SCL rising
                bit_cnt  = bit_cnt + 1'b1;
            end
        end else if (scl_prev === 1'b1 && scl !== 1'b1 && phase != sl_idle) begin
            if (ack_slot) begin
                ack_slot = 1'b0;
                bit_cnt  = '0;
                // Address ACK or master ACK starts the next read byte
                if (phase == sl_read && (!sda_drive || master_ack == ack_level)) begin
                    tx_byte   = mem[pointer];
                    pointer   = pointer + 1'b1;
                    sda_drive = tx_byte[7];
                end else begin
                    sda_drive = 1'b1;
                    if (phase == sl_read) phase = sl_idle;  // NAK ends the read
                end
            end else if (bit_cnt == 4'd8) begin
                ack_slot = 1'b1;
                case (phase)
                    sl_address: begin
                        if (shift_in[7:1] == dev_address) begin
                            sda_drive   = ack_level;
                            first_write = 1'b1;
                            phase       = shift_in[0] ? sl_read : sl_write;
                        end else begin
                            ack_slot = 1'b0;
                            phase    = sl_idle;  // Not ours, wait for the next START
                        end
                    end
                    sl_write: begin
                        sda_drive = ack_level;
                        if (first_write) begin
                            pointer = shift_in[3:0];
                        end else begin
                            mem[pointer] = shift_in;
                            pointer      = pointer + 1'b1;
                        end
                        first_write = 1'b0;
                    end
                    default: sda_drive = 1'b1;  // Master drives the read ACK
                endcase
            end else if (phase == sl_read) begin
                sda_drive = tx_byte[7 - bit_cnt];  // Next bit while SCL is low
            end
        end
        scl_prev = scl;
        sda_prev = sda;
    end

endmodule
